/* hdl/axi_rd_mon_pkg.sv */
package axi_rd_mon_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ID_W      = 8;   // AXI ID
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int USER_W    = 1;   // AR and R user sideband
    localparam int TS_W      = 32;  // Timestamps and latency
    localparam int CNT_W     = 32;  // Statistics counters
    localparam int BIN_W     = 16;  // One histogram bin, wraps
    localparam int HIST_BINS = 16;
    localparam int QOS_W     = 4;

    // ==============================
    // AXI read channels
    // ==============================

    // AR payload, handshake kept as separate wires
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;    // Beats minus one
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [QOS_W-1:0]  qos;
        logic [USER_W-1:0] user;
    } ar_chan_t;

    // R payload
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;   // Final beat of the burst
        logic [USER_W-1:0] user;
    } r_chan_t;

    // ==============================
    // Monitor state
    // ==============================

    // One in-flight read, pushed at AR and retired at rlast
    typedef struct packed {
        logic [TS_W-1:0]  start_ts;  // Cycle of the AR handshake
        logic [QOS_W-1:0] qos;       // ARQOS as accepted
        logic             high_pri;  // Classified at AR time
    } track_rec_t;

    typedef struct packed {
        logic [QOS_W-1:0] qos_high_threshold;  // High priority at or above
        logic [15:0]      qos_timeout_cycles;  // Latency limit for high priority
    } mon_cfg_t;

    typedef struct packed {
        logic [CNT_W-1:0] transaction_count;
        logic [CNT_W-1:0] avg_latency;
        logic [CNT_W-1:0] qos_high_count;
        logic [CNT_W-1:0] qos_low_count;
        logic [CNT_W-1:0] qos_violation_count;
    } perf_stats_t;

    typedef logic [HIST_BINS-1:0][BIN_W-1:0] hist_t;

endpackage

/* hdl/axi_rd_issue.sv */
module axi_rd_issue (
    input  logic                                aclk,
    input  logic                                rst_n,

    // Upstream AR side
    input  axi_rd_mon_pkg::ar_chan_t            s_ar,
    input  logic                                s_arvalid,
    output logic                                s_arready,

    // Downstream ready, gated before it reaches the master
    input  logic                                m_arready,

    // Tracking buffer
    input  logic                                full,
    output logic                                push,
    output axi_rd_mon_pkg::track_rec_t          rec,

    input  logic [axi_rd_mon_pkg::QOS_W-1:0]    cfg_qos_high_threshold,

    // Free-running time base, shared with the consumer
    output logic [axi_rd_mon_pkg::TS_W-1:0]     now_ts,

    // AR side statistics
    output logic [axi_rd_mon_pkg::CNT_W-1:0]    qos_high_count,
    output logic [axi_rd_mon_pkg::CNT_W-1:0]    qos_low_count,
    output axi_rd_mon_pkg::hist_t               qos_hist
);

    logic ar_hs;      // Upstream AR transfer this cycle
    logic high_pri;   // Classification of the AR on the bus

    // ==============================
    // Back-pressure and push
    // ==============================

    // Hold off the master while no record slot is free
    assign s_arready = m_arready & ~full;
    assign ar_hs     = s_arvalid & s_arready;

    assign high_pri = (s_ar.qos >= cfg_qos_high_threshold);

    // Record leaves in the handshake cycle
    assign push         = ar_hs;
    assign rec.start_ts = now_ts;
    assign rec.qos      = s_ar.qos;
    assign rec.high_pri = high_pri;

    // ==============================
    // Time base
    // ==============================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            now_ts <= '0;
        end else begin
            now_ts <= now_ts + 1'b1;  // Wraps, latency math is modular
        end
    end

    // ==============================
    // QoS statistics
    // ==============================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            qos_high_count <= '0;
            qos_low_count  <= '0;
            qos_hist       <= '0;
        end else if (ar_hs) begin
            if (high_pri) begin
                qos_high_count <= qos_high_count + 1'b1;
            end else begin
                qos_low_count  <= qos_low_count + 1'b1;
            end
            // Bin index is the QoS value itself
            qos_hist[s_ar.qos] <= qos_hist[s_ar.qos] + 1'b1;  // 16-bit wrap
        end
    end

endmodule

/* hdl/axi_rd_track_fifo.sv */
module axi_rd_track_fifo #(
    parameter int MAX_OUTSTANDING = 8,  // Record slots
    parameter int OVERLOAD_MARGIN = 2   // Slots below full that count as overload
) (
    input  logic                                      aclk,
    input  logic                                      rst_n,

    // Write side, from the producer
    input  logic                                      push,
    input  axi_rd_mon_pkg::track_rec_t                rec,

    // Read side, to the consumer
    input  logic                                      pop,
    output axi_rd_mon_pkg::track_rec_t                head_rec,

    // Occupancy
    output logic                                      full,
    output logic [$clog2(MAX_OUTSTANDING+1)-1:0]      count,
    output logic                                      busy,
    output logic                                      overload
);

    // Pointer needs at least one bit for a single slot
    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int OCC_W = $clog2(MAX_OUTSTANDING + 1);

    axi_rd_mon_pkg::track_rec_t mem [MAX_OUTSTANDING];  // Record store

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // ==============================
    // Storage
    // ==============================

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= rec;
        end
    end

    assign head_rec = mem[rd_ptr];  // Oldest record, valid while busy

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap, depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push with pop
            endcase
        end
    end

    assign full     = (count == OCC_W'(MAX_OUTSTANDING));
    assign busy     = (count != '0);
    assign overload = (int'(count) > MAX_OUTSTANDING - OVERLOAD_MARGIN);

endmodule

/* hdl/axi_rd_latency_stats.sv */
module axi_rd_latency_stats (
    input  logic                                aclk,
    input  logic                                rst_n,

    // Upstream R handshake
    input  logic                                s_rvalid,
    input  logic                                s_rready,
    input  logic                                s_rlast,

    input  logic [axi_rd_mon_pkg::TS_W-1:0]     now_ts,        // From the producer
    input  axi_rd_mon_pkg::track_rec_t          head_rec,      // Oldest in flight
    input  logic [15:0]                         cfg_qos_timeout_cycles,

    output logic                                pop,

    // Completion statistics
    output logic [axi_rd_mon_pkg::CNT_W-1:0]    transaction_count,
    output logic [axi_rd_mon_pkg::CNT_W-1:0]    avg_latency,
    output logic [axi_rd_mon_pkg::CNT_W-1:0]    qos_violation_count,
    output axi_rd_mon_pkg::hist_t               latency_hist
);

    localparam int BIN_IDX_W = $clog2(axi_rd_mon_pkg::HIST_BINS);
    localparam int SUM_W     = axi_rd_mon_pkg::TS_W + 16;  // Headroom for many long reads

    logic                              done;        // Burst retires this cycle
    logic [axi_rd_mon_pkg::TS_W-1:0]   latency;
    logic [axi_rd_mon_pkg::TS_W-1:0]   timeout_ts;  // Config widened to latency width
    logic                              violation;
    logic [BIN_IDX_W-1:0]              lat_bin;
    logic [SUM_W-1:0]                  latency_sum;
    logic [SUM_W-1:0]                  avg_full;

    // ==============================
    // Completion
    // ==============================

    // In-order slave, so rlast always closes the head record
    assign done = s_rvalid & s_rready & s_rlast;
    assign pop  = done;

    // Modular difference survives a wrap of now_ts
    assign latency = now_ts - head_rec.start_ts;

    // High priority only, strictly above the limit
    assign timeout_ts = axi_rd_mon_pkg::TS_W'(cfg_qos_timeout_cycles);
    assign violation  = head_rec.high_pri && (latency > timeout_ts);

    // Long latencies pile into the top bin
    always_comb begin
        if (latency < axi_rd_mon_pkg::TS_W'(axi_rd_mon_pkg::HIST_BINS)) begin
            lat_bin = latency[BIN_IDX_W-1:0];
        end else begin
            lat_bin = BIN_IDX_W'(axi_rd_mon_pkg::HIST_BINS - 1);
        end
    end

    // ==============================
    // Counters and histogram
    // ==============================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            transaction_count   <= '0;
            latency_sum         <= '0;
            qos_violation_count <= '0;
            latency_hist        <= '0;
        end else if (done) begin
            transaction_count     <= transaction_count + 1'b1;
            latency_sum           <= latency_sum + SUM_W'(latency);
            latency_hist[lat_bin] <= latency_hist[lat_bin] + 1'b1;  // 16-bit wrap
            if (violation) begin
                qos_violation_count <= qos_violation_count + 1'b1;
            end
        end
    end

    // ==============================
    // Average
    // ==============================

    // Truncating divide straight off the registers
    always_comb begin
        if (transaction_count == '0) begin
            avg_full = '0;  // Nothing retired yet
        end else begin
            avg_full = latency_sum / SUM_W'(transaction_count);
        end
    end

    assign avg_latency = axi_rd_mon_pkg::CNT_W'(avg_full);

endmodule

/* hdl/axi_rd_perf_mon.sv */
module axi_rd_perf_mon #(
    parameter int MAX_OUTSTANDING = 8,  // Reads tracked at once
    parameter int OVERLOAD_MARGIN = 2
) (
    input  logic                                      aclk,
    input  logic                                      rst_n,

    // Upstream, from the read master
    input  axi_rd_mon_pkg::ar_chan_t                  s_ar,
    input  logic                                      s_arvalid,
    output logic                                      s_arready,
    output axi_rd_mon_pkg::r_chan_t                   s_r,
    output logic                                      s_rvalid,
    input  logic                                      s_rready,

    // Downstream, to the read slave
    output axi_rd_mon_pkg::ar_chan_t                  m_ar,
    output logic                                      m_arvalid,
    input  logic                                      m_arready,
    input  axi_rd_mon_pkg::r_chan_t                   m_r,
    input  logic                                      m_rvalid,
    output logic                                      m_rready,

    input  axi_rd_mon_pkg::mon_cfg_t                  cfg,

    // Results
    output axi_rd_mon_pkg::perf_stats_t               stats,
    output axi_rd_mon_pkg::hist_t                     latency_hist,
    output axi_rd_mon_pkg::hist_t                     qos_hist,
    output logic [$clog2(MAX_OUTSTANDING+1)-1:0]      active_transactions,
    output logic                                      busy,
    output logic                                      overload
);

    logic                                full;
    logic                                push;
    logic                                pop;
    axi_rd_mon_pkg::track_rec_t          rec;
    axi_rd_mon_pkg::track_rec_t          head_rec;
    logic [axi_rd_mon_pkg::TS_W-1:0]     now_ts;
    logic [axi_rd_mon_pkg::CNT_W-1:0]    qos_high_count;
    logic [axi_rd_mon_pkg::CNT_W-1:0]    qos_low_count;
    logic [axi_rd_mon_pkg::CNT_W-1:0]    transaction_count;
    logic [axi_rd_mon_pkg::CNT_W-1:0]    avg_latency;
    logic [axi_rd_mon_pkg::CNT_W-1:0]    qos_violation_count;

    // ==============================
    // Channel pass-through
    // ==============================

    assign m_ar      = s_ar;
    assign m_arvalid = s_arvalid & ~full;  // Slave must not see an AR the master still holds
    assign s_r       = m_r;
    assign s_rvalid  = m_rvalid;
    assign m_rready  = s_rready;           // R back-pressure untouched

    // ==============================
    // Monitor stages
    // ==============================

    axi_rd_issue axi_rd_issue_inst (
        .aclk                   (aclk),
        .rst_n                  (rst_n),
        .s_ar                   (s_ar),
        .s_arvalid              (s_arvalid),
        .s_arready              (s_arready),
        .m_arready              (m_arready),
        .full                   (full),
        .push                   (push),
        .rec                    (rec),
        .cfg_qos_high_threshold (cfg.qos_high_threshold),
        .now_ts                 (now_ts),
        .qos_high_count         (qos_high_count),
        .qos_low_count          (qos_low_count),
        .qos_hist               (qos_hist)
    );

    axi_rd_track_fifo #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .OVERLOAD_MARGIN (OVERLOAD_MARGIN)
    ) axi_rd_track_fifo_inst (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .push     (push),
        .rec      (rec),
        .pop      (pop),
        .head_rec (head_rec),
        .full     (full),
        .count    (active_transactions),
        .busy     (busy),
        .overload (overload)
    );

    // Retires on the upstream side of the R channel
    axi_rd_latency_stats axi_rd_latency_stats_inst (
        .aclk                   (aclk),
        .rst_n                  (rst_n),
        .s_rvalid               (s_rvalid),
        .s_rready               (s_rready),
        .s_rlast                (s_r.last),
        .now_ts                 (now_ts),
        .head_rec               (head_rec),
        .cfg_qos_timeout_cycles (cfg.qos_timeout_cycles),
        .pop                    (pop),
        .transaction_count      (transaction_count),
        .avg_latency            (avg_latency),
        .qos_violation_count    (qos_violation_count),
        .latency_hist           (latency_hist)
    );

    // Producer and consumer results merged
    assign stats.transaction_count   = transaction_count;
    assign stats.avg_latency         = avg_latency;
    assign stats.qos_high_count      = qos_high_count;
    assign stats.qos_low_count       = qos_low_count;
    assign stats.qos_violation_count = qos_violation_count;

endmodule

/* bench/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // Released on a rising edge
    end

endmodule

/* bench/axi_rd_perf_mon_chk.sv */
module axi_rd_perf_mon_chk #(
    parameter int MAX_OUTSTANDING = 8
) (
    input  logic                                      aclk,
    input  logic                                      rst_n,
    input  logic                                      push,
    input  logic                                      pop,
    input  logic                                      full,
    input  logic [$clog2(MAX_OUTSTANDING+1)-1:0]      count,
    input  logic                                      busy
);

    localparam int OCC_W = $clog2(MAX_OUTSTANDING + 1);

    // ==============================
    // Tracker occupancy rules
    // ==============================

    // In-order completion never retires a record that was not pushed
    pop_not_empty: assert property (@(posedge aclk) disable iff (!rst_n)
        pop |-> (count != '0))
        else $error("Tracker popped while empty");

    // Gated arready keeps the master off a full tracker
    push_not_full: assert property (@(posedge aclk) disable iff (!rst_n)
        push |-> !full)
        else $error("Tracker pushed while full");

    count_in_range: assert property (@(posedge aclk) disable iff (!rst_n)
        count <= OCC_W'(MAX_OUTSTANDING))
        else $error("Tracker count above its depth");

    // Busy rises only after a push and falls only after a pop
    busy_follows_hs: assert property (@(posedge aclk) disable iff (!rst_n)
        (busy != $past(busy)) |-> (busy ? $past(push) : $past(pop)))
        else $error("Busy flag changed without a matching push or pop");

endmodule

bind axi_rd_track_fifo axi_rd_perf_mon_chk #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
) axi_rd_perf_mon_chk_inst (
    .aclk  (aclk),
    .rst_n (rst_n),
    .push  (push),
    .pop   (pop),
    .full  (full),
    .count (count),
    .busy  (busy)
);

/* bench/tb_axi_rd_perf_mon.sv */
module tb_axi_rd_perf_mon;

    localparam int MAX_OUTSTANDING_TB = 4;   // Small, so the tracker fills
    localparam int OVERLOAD_MARGIN_TB = 2;
    localparam int MAX_CASES          = 32;
    localparam int HDR_W              = 3;   // Threshold, timeout, case count
    localparam int CASE_W             = 6;   // id addr len qos delay high_pri
    localparam logic [31:0] LFSR_SEED = 32'hb6e;

    logic aclk;
    logic rst_n;
    axi_rd_mon_pkg::ar_chan_t    s_ar = '0;
    axi_rd_mon_pkg::ar_chan_t    m_ar;
    logic                        s_arvalid = 1'b0;
    logic                        s_arready;
    logic                        m_arvalid;
    logic                        m_arready = 1'b0;
    axi_rd_mon_pkg::r_chan_t     s_r;
    axi_rd_mon_pkg::r_chan_t     m_r = '0;
    logic                        s_rvalid;
    logic                        s_rready = 1'b0;
    logic                        m_rvalid = 1'b0;
    logic                        m_rready;
    axi_rd_mon_pkg::mon_cfg_t    cfg;
    axi_rd_mon_pkg::perf_stats_t stats;
    axi_rd_mon_pkg::hist_t       latency_hist;
    axi_rd_mon_pkg::hist_t       qos_hist;
    logic [$clog2(MAX_OUTSTANDING_TB+1)-1:0] active_transactions;
    logic                        busy;
    logic                        overload;

    // Reference state
    axi_rd_mon_pkg::perf_stats_t exp_stats    = '0;
    axi_rd_mon_pkg::hist_t       exp_lat_hist = '0;
    axi_rd_mon_pkg::hist_t       exp_qos_hist = '0;
    logic [31:0] case_mem [HDR_W + CASE_W * MAX_CASES];
    logic [63:0] lat_sum = '0;
    logic [31:0] lfsr    = LFSR_SEED;
    int n_cases, limit, end_errors;
    int cyc, errors, checks, ar_acc, r_done, occ, max_occ, stalls, beat;
    int ready_cyc [MAX_CASES];  // Cycle after which the slave may answer
    int start_q[$];             // AR handshake cycles, oldest first
    int hp_q[$];
    int slave_q[$];             // Case indices awaiting data

    tb_clk_gen #(.PERIOD(8), .RESET_CYCLES(5)) tb_clk_gen_inst (.clk(aclk), .rst_n(rst_n));

    axi_rd_perf_mon #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING_TB),
        .OVERLOAD_MARGIN (OVERLOAD_MARGIN_TB)
    ) axi_rd_perf_mon_inst (
        .aclk(aclk), .rst_n(rst_n),
        .s_ar(s_ar), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_r(s_r), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
        .m_r(m_r), .m_rvalid(m_rvalid), .m_rready(m_rready),
        .cfg(cfg), .stats(stats), .latency_hist(latency_hist), .qos_hist(qos_hist),
        .active_transactions(active_transactions), .busy(busy), .overload(overload)
    );

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] case_word(int idx, int col);
        return case_mem[HDR_W + idx * CASE_W + col];
    endfunction

    // Galois form, taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic axi_rd_mon_pkg::ar_chan_t make_ar(int idx);
        axi_rd_mon_pkg::ar_chan_t a;
        a       = '0;
        a.id    = 8'(case_word(idx, 0));
        a.addr  = case_word(idx, 1);
        a.len   = 8'(case_word(idx, 2));
        a.size  = 3'd2;   // 4-byte beats
        a.burst = 2'b01;  // INCR
        a.qos   = 4'(case_word(idx, 3));
        return a;
    endfunction

    function automatic axi_rd_mon_pkg::r_chan_t make_r(int idx, int b);
        axi_rd_mon_pkg::r_chan_t r;
        r      = '0;
        r.id   = 8'(case_word(idx, 0));
        r.data = case_word(idx, 1) + 32'(b * 4);  // Beat address as data
        r.last = (b == int'(case_word(idx, 2)));
        return r;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_stats(axi_rd_mon_pkg::perf_stats_t got,
                               axi_rd_mon_pkg::perf_stats_t exp);
        check_val("transaction_count", got.transaction_count, exp.transaction_count);
        check_val("avg_latency", got.avg_latency, exp.avg_latency);
        check_val("qos_high_count", got.qos_high_count, exp.qos_high_count);
        check_val("qos_low_count", got.qos_low_count, exp.qos_low_count);
        check_val("qos_violation_count", got.qos_violation_count, exp.qos_violation_count);
    endtask

    task automatic check_hist(string name, axi_rd_mon_pkg::hist_t got,
                              axi_rd_mon_pkg::hist_t exp);
        for (int b = 0; b < axi_rd_mon_pkg::HIST_BINS; b++) begin
            checks++;
            if (got[4'(b)] !== exp[4'(b)]) begin
                errors++;
                $display("FAIL t=%0t %s[%0d] got=%0h exp=%0h",
                         $time, name, b, got[4'(b)], exp[4'(b)]);
            end
        end
    endtask

    task automatic check_ar(axi_rd_mon_pkg::ar_chan_t got, axi_rd_mon_pkg::ar_chan_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t m_ar got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic check_r(axi_rd_mon_pkg::r_chan_t got, axi_rd_mon_pkg::r_chan_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t s_r got=%h exp=%h", $time, got, exp);
        end
    endtask

    // ==============================
    // Master and slave models
    // ==============================

    always @(posedge aclk) begin : master_drv
        logic b0;
        logic b1;
        if (rst_n) begin
            if (ar_acc < n_cases) begin
                s_arvalid <= 1'b1;
                s_ar      <= make_ar(ar_acc);  // Held until accepted
            end else begin
                s_arvalid <= 1'b0;
            end
            b0       = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            b1       = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            s_rready <= b0 | b1;  // Ready about 3 cycles in 4
        end
    end

    always @(posedge aclk) begin : slave_drv
        if (rst_n) begin
            m_arready <= 1'b1;
            if (slave_q.size() > 0 && cyc > ready_cyc[slave_q[0]]) begin
                m_rvalid <= 1'b1;
                m_r      <= make_r(slave_q[0], beat);
            end else begin
                m_rvalid <= 1'b0;
            end
        end
    end

    // ==============================
    // Reference model and checks
    // ==============================

    // Falling edge, all inputs and outputs settled
    always @(negedge aclk) begin : monitor
        int lat;
        int bin;
        if (rst_n) begin
            check_stats(stats, exp_stats);
            check_hist("latency_hist", latency_hist, exp_lat_hist);
            check_hist("qos_hist", qos_hist, exp_qos_hist);
            check_val("active_transactions", 32'(active_transactions), 32'(occ));
            check_val("busy", 32'(busy), 32'(occ != 0));
            check_val("overload", 32'(overload),
                      32'(occ > MAX_OUTSTANDING_TB - OVERLOAD_MARGIN_TB));
            check_val("s_arready", 32'(s_arready), 32'(m_arready && occ < MAX_OUTSTANDING_TB));
            check_val("m_arvalid", 32'(m_arvalid), 32'(s_arvalid && occ < MAX_OUTSTANDING_TB));
            check_val("s_rvalid", 32'(s_rvalid), 32'(m_rvalid));
            check_val("m_rready", 32'(m_rready), 32'(s_rready));
            check_ar(m_ar, s_ar);
            check_r(s_r, m_r);

            // Handshakes taken at the next rising edge
            if (s_arvalid && !s_arready) stalls++;
            if (s_arvalid && s_arready) begin
                start_q.push_back(cyc);
                hp_q.push_back(int'(case_word(ar_acc, 5)));
                slave_q.push_back(ar_acc);
                ready_cyc[ar_acc] = cyc + int'(case_word(ar_acc, 4));
                if (case_word(ar_acc, 5) != 0) begin
                    exp_stats.qos_high_count = exp_stats.qos_high_count + 32'd1;
                end else begin
                    exp_stats.qos_low_count = exp_stats.qos_low_count + 32'd1;
                end
                exp_qos_hist[s_ar.qos] = exp_qos_hist[s_ar.qos] + 16'd1;
                ar_acc++;
                occ++;
            end
            if (m_rvalid && m_rready) begin
                if (beat == int'(case_word(slave_q[0], 2))) begin
                    void'(slave_q.pop_front());
                    beat = 0;
                end else begin
                    beat++;
                end
            end
            if (s_rvalid && s_rready && s_r.last) begin
                lat = cyc - start_q.pop_front();
                bin = (lat < axi_rd_mon_pkg::HIST_BINS) ? lat : axi_rd_mon_pkg::HIST_BINS - 1;
                exp_lat_hist[4'(bin)] = exp_lat_hist[4'(bin)] + 16'd1;
                exp_stats.transaction_count = exp_stats.transaction_count + 32'd1;
                lat_sum = lat_sum + 64'(lat);
                exp_stats.avg_latency = 32'(lat_sum / 64'(exp_stats.transaction_count));
                if (hp_q.pop_front() != 0 && lat > int'(cfg.qos_timeout_cycles)) begin
                    exp_stats.qos_violation_count = exp_stats.qos_violation_count + 32'd1;
                end
                r_done++;
                occ--;
            end
            if (occ > max_occ) max_occ = occ;
            cyc++;
        end
    end

    // ==============================
    // Run control
    // ==============================

    initial begin
        $readmemh("bench/rd_cases.txt", case_mem);
        cfg.qos_high_threshold = 4'(case_mem[0]);
        cfg.qos_timeout_cycles = 16'(case_mem[1]);
        n_cases = int'(case_mem[2]);
        limit   = 200;  // Margin for issue and pipeline slack
        for (int i = 0; i < n_cases; i++) begin
            limit += 4 * (int'(case_word(i, 2)) + 1) + int'(case_word(i, 4));
        end
        @(posedge rst_n);
        while (r_done < n_cases) @(negedge aclk);
        repeat (2) @(negedge aclk);  // Let the last counters settle and be compared
        if (max_occ != MAX_OUTSTANDING_TB) begin
            end_errors++;
            $display("Tracker never held %0d reads at once", MAX_OUTSTANDING_TB);
        end
        if (stalls == 0) begin
            end_errors++;
            $display("Master was never held off by a full tracker");
        end
        if (exp_stats.qos_violation_count == 0) begin
            end_errors++;
            $display("No QoS violation was exercised");
        end
        $display("Checks: %0d, errors: %0d", checks, errors + end_errors);
        if (errors + end_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        @(posedge rst_n);
        while (cyc < limit) @(negedge aclk);
        $display("Timeout after %0d cycles, %0d of %0d reads retired", cyc, r_done, n_cases);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* bench/rd_cases.txt */
// Header, hex: qos_high_threshold qos_timeout_cycles case_count
// Cases, hex: id addr len qos slave_delay high_pri
8 14 10
// Short bursts, tracker fills behind the long ones
01 00001000 00 0 00 0
02 00001040 03 8 02 1
03 00002000 01 f 00 1
04 00002100 07 3 04 0
// Long slave delays on high and low QoS
05 00003000 00 a 1e 1
06 00003040 02 2 1e 0
07 00004000 00 9 00 1
08 00004080 01 1 03 0
09 00005000 03 c 28 1
0a 00005100 00 7 28 0
// Sixteen-beat burst
0b 00006000 0f 8 00 1
0c 00006400 00 0 05 0
0d 00007000 01 e 01 1
0e 00007100 02 4 00 0
// QoS right at the threshold
0f 00008000 00 8 19 1
10 00008040 00 6 02 0

/* all.f */
hdl/axi_rd_mon_pkg.sv
hdl/axi_rd_issue.sv
hdl/axi_rd_track_fifo.sv
hdl/axi_rd_latency_stats.sv
hdl/axi_rd_perf_mon.sv
bench/tb_clk_gen.sv
bench/axi_rd_perf_mon_chk.sv
bench/tb_axi_rd_perf_mon.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_axi_rd_perf_mon
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Testbench passed
FAIL_MSG   = Testbench failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
